// File: common/cp0_pkg.sv
package cp0_pkg;

	// register numbers seen on the bus
	typedef enum logic [4:0] {
		BADVADDR = 5'd8,
		COUNT    = 5'd9,
		COMPARE  = 5'd11,
		STATUS   = 5'd12,
		CAUSE    = 5'd13,
		EPC      = 5'd14,
		PRID     = 5'd15
	} cp0_reg_t;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} cp0_op_t;

	typedef enum logic [4:0] {
		INT  = 5'd0,
		MOD  = 5'd1,
		TLBL = 5'd2,
		TLBS = 5'd3,
		ADEL = 5'd4,
		ADES = 5'd5,
		SYS  = 5'd8,
		BP   = 5'd9,
		RI   = 5'd10,
		OV   = 5'd12
	} exc_code_t;

	// highest priority first
	typedef struct packed {
		logic fetch_adel;
		logic reserved_instr;
		logic itlb_miss;
		logic overflow;
		logic trap;
		logic syscall;
		logic dtlb_miss;
		logic dtlb_mod;
		logic data_adel;
		logic data_ades;
	} exc_flags_t;

	typedef enum logic [1:0] {
		SRC_NONE = 2'd0,
		SRC_PC   = 2'd1,
		SRC_DATA = 2'd2
	} vaddr_src_t;

	localparam logic [31:0] PRID_VALUE   = 32'h00004220;
	// only bev set
	localparam logic [31:0] STATUS_RESET = 32'h00400000;
	// im, exl, ie
	localparam logic [31:0] STATUS_WMASK = 32'h0000ff03;
	// software ip bits
	localparam logic [31:0] CAUSE_WMASK  = 32'h00000300;
	localparam logic [31:0] EXC_VECTOR   = 32'hbfc00380;

	// field positions
	localparam int STATUS_IE     = 0;
	localparam int STATUS_EXL    = 1;
	localparam int STATUS_IM_LSB = 8;
	localparam int CAUSE_EXC_LSB = 2;
	localparam int CAUSE_IP_LSB  = 8;
	localparam int CAUSE_HW_LSB  = 10;
	localparam int CAUSE_TI      = 30;
	localparam int CAUSE_BD      = 31;

endpackage

// File: common/cp0_bus_if.sv
`timescale 1ns/1ps

// four-phase req/ack register bus
interface cp0_bus_if;
	logic req;
	logic ack;
	cp0_pkg::cp0_op_t op;
	logic [4:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;

	modport requester (
		output req,
		output op,
		output addr,
		output wdata,
		input ack,
		input rdata
	);

	modport responder (
		input req,
		input op,
		input addr,
		input wdata,
		output ack,
		output rdata
	);
endinterface

// File: hw/cp0_arbiter.sv
`timescale 1ns/1ps

module cp0_arbiter (
	input logic clk,
	input logic reset,
	cp0_bus_if.responder core_bus,
	cp0_bus_if.responder dbg_bus,
	cp0_bus_if.requester bank_bus
);
	typedef enum logic [1:0] {
		IDLE,
		CORE,
		DBG
	} grant_t;

	grant_t grant;
	// set when debug won last, so core goes first after reset
	logic last_dbg;

	always_ff @(posedge clk) begin
		if (reset) begin
			grant <= IDLE;
			last_dbg <= 1'b1;
		end else begin
			case (grant)
				IDLE: begin
					if (core_bus.req && (!dbg_bus.req || last_dbg)) begin
						grant <= CORE;
						last_dbg <= 1'b0;
					end else if (dbg_bus.req) begin
						grant <= DBG;
						last_dbg <= 1'b1;
					end
				end
				// hold until all four phases are closed
				CORE: if (!core_bus.req && !bank_bus.ack) grant <= IDLE;
				DBG: if (!dbg_bus.req && !bank_bus.ack) grant <= IDLE;
				default: grant <= IDLE;
			endcase
		end
	end

	always_comb begin
		bank_bus.req = 1'b0;
		bank_bus.op = cp0_pkg::OP_READ;
		bank_bus.addr = '0;
		bank_bus.wdata = '0;
		core_bus.ack = 1'b0;
		core_bus.rdata = '0;
		dbg_bus.ack = 1'b0;
		dbg_bus.rdata = '0;
		case (grant)
			CORE: begin
				bank_bus.req = core_bus.req;
				bank_bus.op = core_bus.op;
				bank_bus.addr = core_bus.addr;
				bank_bus.wdata = core_bus.wdata;
				core_bus.ack = bank_bus.ack;
				core_bus.rdata = bank_bus.rdata;
			end
			DBG: begin
				bank_bus.req = dbg_bus.req;
				bank_bus.op = dbg_bus.op;
				bank_bus.addr = dbg_bus.addr;
				bank_bus.wdata = dbg_bus.wdata;
				dbg_bus.ack = bank_bus.ack;
				dbg_bus.rdata = bank_bus.rdata;
			end
			default: ;
		endcase
	end

	// the bank only acks a request it saw, so the grant was already held an edge earlier
	grant_held: assert property (@(posedge clk) disable iff (reset)
		(core_bus.ack -> (grant == CORE && $past(grant) == CORE)) &&
		(dbg_bus.ack -> (grant == DBG && $past(grant) == DBG)));

endmodule

// File: cp0/cp0_exc_encoder.sv
`timescale 1ns/1ps

module cp0_exc_encoder (
	input cp0_pkg::exc_flags_t flags,
	input logic exc_valid,
	output cp0_pkg::exc_code_t code,
	output cp0_pkg::vaddr_src_t vaddr_src,
	output logic exc_taken
);
	assign exc_taken = exc_valid && (|flags);

	// first flag set wins, in struct order
	always_comb begin
		code = cp0_pkg::INT;
		vaddr_src = cp0_pkg::SRC_NONE;
		if (flags.fetch_adel) begin
			code = cp0_pkg::ADEL;
			vaddr_src = cp0_pkg::SRC_PC;
		end else if (flags.reserved_instr) begin
			code = cp0_pkg::RI;
		end else if (flags.itlb_miss) begin
			code = cp0_pkg::TLBL;
			vaddr_src = cp0_pkg::SRC_PC;
		end else if (flags.overflow) begin
			code = cp0_pkg::OV;
		end else if (flags.trap) begin
			code = cp0_pkg::BP;
		end else if (flags.syscall) begin
			code = cp0_pkg::SYS;
		end else if (flags.dtlb_miss) begin
			code = cp0_pkg::TLBS;
			vaddr_src = cp0_pkg::SRC_DATA;
		end else if (flags.dtlb_mod) begin
			code = cp0_pkg::MOD;
			vaddr_src = cp0_pkg::SRC_DATA;
		end else if (flags.data_adel) begin
			code = cp0_pkg::ADEL;
			vaddr_src = cp0_pkg::SRC_DATA;
		end else if (flags.data_ades) begin
			code = cp0_pkg::ADES;
			vaddr_src = cp0_pkg::SRC_DATA;
		end
	end

endmodule

// File: cp0/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs (
	input logic clk,
	input logic reset,
	cp0_bus_if.responder bus,
	input logic exc_taken,
	input cp0_pkg::exc_code_t code,
	input cp0_pkg::vaddr_src_t vaddr_src,
	input logic [31:0] pc,
	input logic [31:0] vaddr,
	input logic in_slot,
	input logic eret,
	input logic [5:0] ext_int,
	output logic irq,
	output logic [31:0] epc_out,
	output logic [31:0] vector
);
	logic [31:0] status;
	logic [31:0] cause;
	logic [31:0] epc;
	logic [31:0] bad_vaddr;
	logic [31:0] count;
	logic [31:0] compare;
	logic ti;
	logic tick;
	logic [31:0] cause_rd;
	logic [31:0] rmux;
	logic [7:0] pending;
	cp0_pkg::cp0_reg_t reg_sel;
	logic do_write;
	logic count_wr;
	logic compare_wr;

	assign reg_sel = cp0_pkg::cp0_reg_t'(bus.addr);
	// an exception in the same cycle holds the write back by one edge
	assign do_write = bus.req && !bus.ack && bus.op == cp0_pkg::OP_WRITE && !exc_taken;
	assign count_wr = do_write && reg_sel == cp0_pkg::COUNT;
	assign compare_wr = do_write && reg_sel == cp0_pkg::COMPARE;

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.ack <= 1'b0;
		end else if (!bus.ack && bus.req) begin
			bus.ack <= !(bus.op == cp0_pkg::OP_WRITE && exc_taken);
		end else if (bus.ack && !bus.req) begin
			bus.ack <= 1'b0;
		end
	end

	// read data captured as ack rises, stable for the rest of the handshake
	always_ff @(posedge clk) begin
		if (bus.req && !bus.ack)
			bus.rdata <= rmux;
	end

	always_comb begin
		cause_rd = cause;
		cause_rd[cp0_pkg::CAUSE_TI] = ti;
		cause_rd[cp0_pkg::CAUSE_HW_LSB +: 6] = ext_int;
	end

	always_comb begin
		case (reg_sel)
			cp0_pkg::BADVADDR: rmux = bad_vaddr;
			cp0_pkg::COUNT: rmux = count;
			cp0_pkg::COMPARE: rmux = compare;
			cp0_pkg::STATUS: rmux = status;
			cp0_pkg::CAUSE: rmux = cause_rd;
			cp0_pkg::EPC: rmux = epc;
			cp0_pkg::PRID: rmux = cp0_pkg::PRID_VALUE;
			default: rmux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			status <= cp0_pkg::STATUS_RESET;
			cause <= '0;
		end else if (exc_taken) begin
			status[cp0_pkg::STATUS_EXL] <= 1'b1;
			cause[cp0_pkg::CAUSE_EXC_LSB +: 5] <= code;
			// nested exception keeps epc and bd
			if (!status[cp0_pkg::STATUS_EXL])
				cause[cp0_pkg::CAUSE_BD] <= in_slot;
		end else begin
			if (do_write && reg_sel == cp0_pkg::STATUS)
				status <= (status & ~cp0_pkg::STATUS_WMASK) |
					(bus.wdata & cp0_pkg::STATUS_WMASK);
			if (do_write && reg_sel == cp0_pkg::CAUSE)
				cause <= (cause & ~cp0_pkg::CAUSE_WMASK) |
					(bus.wdata & cp0_pkg::CAUSE_WMASK);
			if (eret)
				status[cp0_pkg::STATUS_EXL] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (exc_taken) begin
			if (!status[cp0_pkg::STATUS_EXL])
				epc <= in_slot ? pc - 32'd4 : pc;
			case (vaddr_src)
				cp0_pkg::SRC_PC: bad_vaddr <= pc;
				cp0_pkg::SRC_DATA: bad_vaddr <= vaddr;
				default: ;
			endcase
		end else if (do_write && reg_sel == cp0_pkg::EPC) begin
			epc <= bus.wdata;
		end
	end

	// count steps every second edge
	always_ff @(posedge clk) begin
		if (reset) begin
			tick <= 1'b0;
			count <= '0;
			compare <= '0;
			ti <= 1'b0;
		end else begin
			tick <= !tick;
			if (count_wr)
				count <= bus.wdata;
			else if (tick)
				count <= count + 32'd1;
			if (compare_wr)
				compare <= bus.wdata;
			// ti set as count steps onto compare
			if (compare_wr)
				ti <= 1'b0;
			else if (tick && !count_wr && count + 32'd1 == compare)
				ti <= 1'b1;
		end
	end

	// timer shares ip7 with the top external line
	assign pending = {ext_int[5] | ti, ext_int[4:0], cause[cp0_pkg::CAUSE_IP_LSB +: 2]};
	assign irq = status[cp0_pkg::STATUS_IE] && !status[cp0_pkg::STATUS_EXL] &&
		(|(pending & status[cp0_pkg::STATUS_IM_LSB +: 8]));

	assign epc_out = epc;
	assign vector = cp0_pkg::EXC_VECTOR;

	ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$fell(bus.ack) |-> !$past(bus.req));

	exc_over_eret: assert property (@(posedge clk) disable iff (reset)
		(exc_taken && eret) |=> status[cp0_pkg::STATUS_EXL]);

endmodule

// File: hw/cp0_top.sv
`timescale 1ns/1ps

module cp0_top (
	input logic clk,
	input logic reset,
	input logic core_req,
	input cp0_pkg::cp0_op_t core_op,
	input logic [4:0] core_addr,
	input logic [31:0] core_wdata,
	output logic core_ack,
	output logic [31:0] core_rdata,
	input logic dbg_req,
	input cp0_pkg::cp0_op_t dbg_op,
	input logic [4:0] dbg_addr,
	input logic [31:0] dbg_wdata,
	output logic dbg_ack,
	output logic [31:0] dbg_rdata,
	input logic exc_valid,
	input cp0_pkg::exc_flags_t flags,
	input logic [31:0] pc,
	input logic [31:0] vaddr,
	input logic in_slot,
	input logic eret,
	input logic [5:0] ext_int,
	output logic irq,
	output logic exc_taken,
	output logic [31:0] epc_out,
	output logic [31:0] vector
);
	cp0_bus_if core_if ();
	cp0_bus_if dbg_if ();
	cp0_bus_if bank_if ();

	cp0_pkg::exc_code_t code;
	cp0_pkg::vaddr_src_t vaddr_src;

	assign core_if.req = core_req;
	assign core_if.op = core_op;
	assign core_if.addr = core_addr;
	assign core_if.wdata = core_wdata;
	assign core_ack = core_if.ack;
	assign core_rdata = core_if.rdata;

	assign dbg_if.req = dbg_req;
	assign dbg_if.op = dbg_op;
	assign dbg_if.addr = dbg_addr;
	assign dbg_if.wdata = dbg_wdata;
	assign dbg_ack = dbg_if.ack;
	assign dbg_rdata = dbg_if.rdata;

	cp0_arbiter u_arbiter (
		.clk(clk),
		.reset(reset),
		.core_bus(core_if),
		.dbg_bus(dbg_if),
		.bank_bus(bank_if)
	);

	cp0_exc_encoder u_encoder (
		.flags(flags),
		.exc_valid(exc_valid),
		.code(code),
		.vaddr_src(vaddr_src),
		.exc_taken(exc_taken)
	);

	cp0_regs u_regs (
		.clk(clk),
		.reset(reset),
		.bus(bank_if),
		.exc_taken(exc_taken),
		.code(code),
		.vaddr_src(vaddr_src),
		.pc(pc),
		.vaddr(vaddr),
		.in_slot(in_slot),
		.eret(eret),
		.ext_int(ext_int),
		.irq(irq),
		.epc_out(epc_out),
		.vector(vector)
	);

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

// 100 ns clock, reset held for the first 10 rising edges
module tb_clk_gen (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end
endmodule

// File: verif/cp0_tb.sv
`timescale 1ns/1ps

module cp0_tb;
	localparam logic [31:0] PRID_EXP = 32'h00004220;
	localparam logic [31:0] STATUS_RST = 32'h00400000;
	localparam logic [31:0] STATUS_MASK = 32'h0000ff03;
	localparam logic [31:0] CAUSE_MASK = 32'h00000300;
	localparam logic [31:0] VECTOR_EXP = 32'hbfc00380;
	localparam int ACK_LIMIT = 20;
	localparam int TIMER_LIMIT = 200;
	localparam int RESET_LIMIT = 40;

	typedef enum logic [2:0] {
		K_WRITE, K_READ, K_EXC, K_ERET, K_EXT, K_IRQ, K_TIMER, K_PAIR
	} kind_t;

	// one stimulus step; data is write data, pc, ext_int or timer offset
	typedef struct packed {
		kind_t kind;
		logic port;
		logic [4:0] addr;
		logic [31:0] data;
		logic [31:0] vaddr;
		logic [9:0] flags;
		logic in_slot;
		logic [31:0] exp;
	} row_t;

	logic clk;
	logic reset;
	logic core_req;
	cp0_pkg::cp0_op_t core_op;
	logic [4:0] core_addr;
	logic [31:0] core_wdata;
	logic core_ack;
	logic [31:0] core_rdata;
	logic dbg_req;
	cp0_pkg::cp0_op_t dbg_op;
	logic [4:0] dbg_addr;
	logic [31:0] dbg_wdata;
	logic dbg_ack;
	logic [31:0] dbg_rdata;
	logic exc_valid;
	cp0_pkg::exc_flags_t flags;
	logic [31:0] pc;
	logic [31:0] vaddr;
	logic in_slot;
	logic eret;
	logic [5:0] ext_int;
	logic irq;
	logic exc_taken;
	logic [31:0] epc_out;
	logic [31:0] vector;

	row_t rows[$];
	logic [31:0] rng;
	logic [31:0] rd_a;
	logic [31:0] rd_b;

	// expected register contents while the table is built
	logic [31:0] status_m;
	logic [31:0] cause_m;
	logic [31:0] epc_m;
	logic [31:0] badv_m;
	logic [31:0] cmp_m;
	logic [5:0] ext_m;
	logic badv_ok;

	tb_clk_gen clk_gen (
		.clk(clk),
		.reset(reset)
	);

	cp0_top uut (
		.clk(clk), .reset(reset),
		.core_req(core_req), .core_op(core_op), .core_addr(core_addr),
		.core_wdata(core_wdata), .core_ack(core_ack), .core_rdata(core_rdata),
		.dbg_req(dbg_req), .dbg_op(dbg_op), .dbg_addr(dbg_addr),
		.dbg_wdata(dbg_wdata), .dbg_ack(dbg_ack), .dbg_rdata(dbg_rdata),
		.exc_valid(exc_valid), .flags(flags), .pc(pc), .vaddr(vaddr),
		.in_slot(in_slot), .eret(eret), .ext_int(ext_int),
		.irq(irq), .exc_taken(exc_taken), .epc_out(epc_out), .vector(vector)
	);

	task stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// {source, code}: source 0 none, 1 pc, 2 data address
	function automatic logic [6:0] rank_flags(input logic [9:0] f);
		logic [6:0] r;
		r = 7'd0;
		if (f[9]) r = {2'd1, 5'd4};
		else if (f[8]) r = {2'd0, 5'd10};
		else if (f[7]) r = {2'd1, 5'd2};
		else if (f[6]) r = {2'd0, 5'd12};
		else if (f[5]) r = {2'd0, 5'd9};
		else if (f[4]) r = {2'd0, 5'd8};
		else if (f[3]) r = {2'd2, 5'd3};
		else if (f[2]) r = {2'd2, 5'd1};
		else if (f[1]) r = {2'd2, 5'd4};
		else if (f[0]) r = {2'd2, 5'd5};
		return r;
	endfunction

	function logic [31:0] model_read(input logic [4:0] a);
		case (a)
			cp0_pkg::STATUS: return status_m;
			cp0_pkg::CAUSE: return cause_m | {16'd0, ext_m, 10'd0};
			cp0_pkg::EPC: return epc_m;
			cp0_pkg::BADVADDR: return badv_m;
			cp0_pkg::COMPARE: return cmp_m;
			cp0_pkg::PRID: return PRID_EXP;
			default: return 32'd0;
		endcase
	endfunction

	task add_row(input kind_t k, input logic p, input logic [4:0] a, input logic [31:0] d,
		input logic [31:0] v, input logic [9:0] f, input logic s, input logic [31:0] e);
		row_t r;
		r.kind = k;
		r.port = p;
		r.addr = a;
		r.data = d;
		r.vaddr = v;
		r.flags = f;
		r.in_slot = s;
		r.exp = e;
		rows.push_back(r);
	endtask

	task model_write(input logic [4:0] a, input logic [31:0] d);
		case (a)
			cp0_pkg::STATUS: status_m = (status_m & ~STATUS_MASK) | (d & STATUS_MASK);
			cp0_pkg::CAUSE: cause_m = (cause_m & ~CAUSE_MASK) | (d & CAUSE_MASK);
			cp0_pkg::EPC: epc_m = d;
			cp0_pkg::COMPARE: cmp_m = d;
			default: ;
		endcase
	endtask

	task add_write(input logic p, input logic [4:0] a, input logic [31:0] d);
		add_row(K_WRITE, p, a, d, 32'd0, 10'd0, 1'b0, 32'd0);
		model_write(a, d);
	endtask

	task add_read(input logic p, input logic [4:0] a);
		add_row(K_READ, p, a, 32'd0, 32'd0, 10'd0, 1'b0, model_read(a));
	endtask

	task add_irq(input logic e);
		add_row(K_IRQ, 1'b0, 5'd0, 32'd0, 32'd0, 10'd0, 1'b0, {31'd0, e});
	endtask

	task add_ext(input logic [5:0] v);
		add_row(K_EXT, 1'b0, 5'd0, {26'd0, v}, 32'd0, 10'd0, 1'b0, 32'd0);
		ext_m = v;
	endtask

	task add_eret();
		add_row(K_ERET, 1'b0, 5'd0, 32'd0, 32'd0, 10'd0, 1'b0, 32'd0);
		status_m[1] = 1'b0;
		add_read(1'b0, cp0_pkg::STATUS);
	endtask

	// epc and bd only move when exl was clear
	task add_exc(input logic [9:0] f, input logic [31:0] pcv, input logic [31:0] va,
		input logic s);
		logic [6:0] r;
		r = rank_flags(f);
		if (!status_m[1]) begin
			epc_m = s ? pcv - 32'd4 : pcv;
			cause_m[31] = s;
		end
		status_m[1] = 1'b1;
		cause_m[6:2] = r[4:0];
		if (r[6:5] == 2'd1) begin
			badv_m = pcv;
			badv_ok = 1'b1;
		end else if (r[6:5] == 2'd2) begin
			badv_m = va;
			badv_ok = 1'b1;
		end
		add_row(K_EXC, 1'b0, 5'd0, pcv, va, f, s, epc_m);
		add_read(1'b0, cp0_pkg::STATUS);
		add_read(1'b0, cp0_pkg::CAUSE);
		add_read(1'b1, cp0_pkg::EPC);
		if (badv_ok)
			add_read(1'b1, cp0_pkg::BADVADDR);
	endtask

	// writer on port p, reader on the other port, same register
	task add_pair(input logic p, input logic [4:0] a, input logic [31:0] d);
		add_row(K_PAIR, p, a, d, 32'd0, 10'd0, 1'b0, model_read(a));
		model_write(a, d);
		add_read(!p, a);
	endtask

	task build_table();
		logic [31:0] d;
		logic [4:0] regs [4];
		regs[0] = cp0_pkg::STATUS;
		regs[1] = cp0_pkg::CAUSE;
		regs[2] = cp0_pkg::EPC;
		regs[3] = cp0_pkg::COMPARE;
		add_read(1'b0, cp0_pkg::PRID);
		add_read(1'b1, cp0_pkg::STATUS);
		add_read(1'b0, cp0_pkg::CAUSE);
		add_irq(1'b0);
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 4; j++) begin
				d = next_rand();
				add_write(d[31], regs[j], d);
				add_read(!d[31], regs[j]);
			end
		end
		add_write(1'b1, cp0_pkg::PRID, next_rand());
		add_read(1'b0, cp0_pkg::PRID);
		add_write(1'b0, 5'd3, next_rand());
		add_read(1'b1, 5'd3);
		add_write(1'b1, 5'd20, next_rand());
		add_read(1'b0, 5'd20);
		add_write(1'b0, cp0_pkg::STATUS, 32'd0);
		add_write(1'b0, cp0_pkg::CAUSE, 32'd0);
		// one flag at a time, fetch_adel first so bad_vaddr is known
		for (int k = 9; k >= 0; k--) begin
			d = next_rand();
			add_exc(10'd1 << k, d, next_rand(), d[7]);
			add_eret();
		end
		// nested: code changes, epc stays
		add_exc(10'h010, next_rand(), next_rand(), 1'b1);
		add_exc(10'h040, next_rand(), next_rand(), 1'b0);
		add_eret();
		// several flags, highest rank wins
		add_exc(10'h049, next_rand(), next_rand(), 1'b0);
		add_eret();
		add_exc(10'h092, next_rand(), next_rand(), 1'b1);
		add_eret();
		add_exc(10'h007, next_rand(), next_rand(), 1'b0);
		add_eret();
		add_exc(10'h3ff, next_rand(), next_rand(), 1'b0);
		add_eret();
		// software bit ip0 under im0
		add_write(1'b0, cp0_pkg::STATUS, 32'h00000101);
		add_irq(1'b0);
		add_write(1'b1, cp0_pkg::CAUSE, 32'h00000100);
		add_irq(1'b1);
		add_write(1'b0, cp0_pkg::STATUS, 32'h00000103);
		add_irq(1'b0);
		add_write(1'b0, cp0_pkg::STATUS, 32'h00000101);
		add_irq(1'b1);
		add_write(1'b1, cp0_pkg::CAUSE, 32'd0);
		add_irq(1'b0);
		// ext_int[0] under im2
		add_write(1'b0, cp0_pkg::STATUS, 32'h00000401);
		add_ext(6'h01);
		add_irq(1'b1);
		add_exc(10'h020, next_rand(), next_rand(), 1'b0);
		add_irq(1'b0);
		add_eret();
		add_irq(1'b1);
		add_ext(6'h00);
		add_irq(1'b0);
		// timer under im7
		add_write(1'b0, cp0_pkg::STATUS, 32'h00008001);
		add_row(K_TIMER, 1'b0, 5'd0, 32'd20, 32'd0, 10'd0, 1'b0, 32'd0);
		cmp_m = 32'd0;
		add_pair(1'b0, cp0_pkg::EPC, next_rand());
		add_pair(1'b1, cp0_pkg::EPC, next_rand());
	endtask

	task automatic bus_xfer(input logic port, input cp0_pkg::cp0_op_t op, input logic [4:0] addr,
		input logic [31:0] data, output logic [31:0] rd);
		int n;
		@(negedge clk);
		if (port) begin
			dbg_op = op;
			dbg_addr = addr;
			dbg_wdata = data;
			dbg_req = 1'b1;
		end else begin
			core_op = op;
			core_addr = addr;
			core_wdata = data;
			core_req = 1'b1;
		end
		n = 0;
		while (!(port ? dbg_ack : core_ack)) begin
			@(negedge clk);
			n++;
			if (n > ACK_LIMIT)
				stop_run($sformatf("timeout waiting for %s ack to rise", port ? "dbg" : "core"));
		end
		rd = port ? dbg_rdata : core_rdata;
		if (port)
			dbg_req = 1'b0;
		else
			core_req = 1'b0;
		n = 0;
		while (port ? dbg_ack : core_ack) begin
			@(negedge clk);
			n++;
			if (n > ACK_LIMIT)
				stop_run($sformatf("timeout waiting for %s ack to fall", port ? "dbg" : "core"));
		end
	endtask

	// compare set a little above count, wait for ti, then clear it
	task run_timer(input logic [31:0] offset);
		int n;
		bus_xfer(1'b0, cp0_pkg::OP_READ, cp0_pkg::COUNT, 32'd0, rd_a);
		bus_xfer(1'b1, cp0_pkg::OP_WRITE, cp0_pkg::COMPARE, rd_a + offset, rd_b);
		check_value("irq", {31'd0, irq}, 32'd0);
		n = 0;
		while (irq !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > TIMER_LIMIT)
				stop_run("timeout waiting for the timer interrupt");
		end
		bus_xfer(1'b0, cp0_pkg::OP_WRITE, cp0_pkg::COMPARE, 32'd0, rd_b);
		@(negedge clk);
		check_value("irq", {31'd0, irq}, 32'd0);
	endtask

	task apply_row(input row_t r);
		case (r.kind)
			K_WRITE: bus_xfer(r.port, cp0_pkg::OP_WRITE, r.addr, r.data, rd_a);
			K_READ: begin
				bus_xfer(r.port, cp0_pkg::OP_READ, r.addr, 32'd0, rd_a);
				check_value($sformatf("%s_rdata[reg %0d]", r.port ? "dbg" : "core", r.addr),
					rd_a, r.exp);
			end
			K_EXC: begin
				@(negedge clk);
				exc_valid = 1'b1;
				flags = r.flags;
				pc = r.data;
				vaddr = r.vaddr;
				in_slot = r.in_slot;
				@(posedge clk);
				check_value("exc_taken", {31'd0, exc_taken}, 32'd1);
				@(negedge clk);
				exc_valid = 1'b0;
				flags = '0;
				in_slot = 1'b0;
				check_value("epc_out", epc_out, r.exp);
			end
			K_ERET: begin
				@(negedge clk);
				eret = 1'b1;
				@(negedge clk);
				eret = 1'b0;
			end
			K_EXT: begin
				@(negedge clk);
				ext_int = r.data[5:0];
			end
			K_IRQ: begin
				@(negedge clk);
				check_value("irq", {31'd0, irq}, r.exp);
			end
			K_TIMER: run_timer(r.data);
			K_PAIR: begin
				fork
					bus_xfer(r.port, cp0_pkg::OP_WRITE, r.addr, r.data, rd_b);
					bus_xfer(!r.port, cp0_pkg::OP_READ, r.addr, 32'd0, rd_a);
				join
				// either order is legal, so old or new value
				if (rd_a !== r.exp && rd_a !== r.data)
					check_value($sformatf("%s_rdata[reg %0d]", r.port ? "core" : "dbg", r.addr),
						rd_a, r.exp);
			end
			default: stop_run("unknown row kind in the stimulus table");
		endcase
	endtask

	initial begin
		int n;
		core_req = 1'b0;
		core_op = cp0_pkg::OP_READ;
		core_addr = '0;
		core_wdata = '0;
		dbg_req = 1'b0;
		dbg_op = cp0_pkg::OP_READ;
		dbg_addr = '0;
		dbg_wdata = '0;
		exc_valid = 1'b0;
		flags = '0;
		pc = '0;
		vaddr = '0;
		in_slot = 1'b0;
		eret = 1'b0;
		ext_int = '0;
		rng = 32'he7e4b511;
		status_m = STATUS_RST;
		cause_m = 32'd0;
		epc_m = 32'd0;
		badv_m = 32'd0;
		cmp_m = 32'd0;
		ext_m = 6'd0;
		badv_ok = 1'b0;
		build_table();
		n = 0;
		while (reset !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > RESET_LIMIT)
				stop_run("timeout waiting for reset to be released");
		end
		@(negedge clk);
		check_value("core_ack", {31'd0, core_ack}, 32'd0);
		check_value("dbg_ack", {31'd0, dbg_ack}, 32'd0);
		check_value("exc_taken", {31'd0, exc_taken}, 32'd0);
		check_value("vector", vector, VECTOR_EXP);
		foreach (rows[i])
			apply_row(rows[i]);
		$display("Test passed");
		$finish;
	end
endmodule

// File: tb.f
common/cp0_pkg.sv
common/cp0_bus_if.sv
hw/cp0_arbiter.sv
cp0/cp0_exc_encoder.sv
cp0/cp0_regs.sv
hw/cp0_top.sv
verif/tb_clk_gen.sv
verif/cp0_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cp0 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cp0_tb \
	-f tb.f --Mdir obj_dir -o cp0_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/cp0_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0
